// ==== bp_pkg.sv ====
// Branch predictor shared types
package bp_pkg;

    // RV32 major opcodes seen by the resolver
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_OTHER  = 7'b0010011
    } opcode_e;

    // Class of a resolved instruction
    typedef enum logic [1:0] {
        CLASS_NONE   = 2'd0,
        CLASS_BRANCH = 2'd1,
        CLASS_JUMP   = 2'd2
    } instr_class_e;

    // Default table sizes
    localparam int DEFAULT_BTB_ENTRIES = 32;
    localparam int DEFAULT_GHR_BITS    = 5;

endpackage

// ==== btb.sv ====
// Branch target buffer
module btb #(
    parameter int NUM_BTB_ENTRIES = bp_pkg::DEFAULT_BTB_ENTRIES
) (
    input  logic        clk,
    input  logic        reset_i,
    input  logic [31:0] pc_i,
    output logic        hit_o,
    output logic        jump_o,
    output logic        branch_o,
    output logic [31:0] target_o,
    input  logic        we_i,
    input  logic [31:0] wr_pc_i,
    input  logic [31:0] wr_target_i,
    input  logic        wr_jump_i,
    input  logic        wr_branch_i
);

    localparam int IDX_BITS = $clog2(NUM_BTB_ENTRIES);

    logic [31:0] tag_mem    [NUM_BTB_ENTRIES];
    logic [31:0] target_mem [NUM_BTB_ENTRIES];
    logic        jump_mem   [NUM_BTB_ENTRIES];
    logic        branch_mem [NUM_BTB_ENTRIES];
    logic [NUM_BTB_ENTRIES-1:0] valid_q;

    logic [IDX_BITS-1:0] rd_idx;
    logic [IDX_BITS-1:0] wr_idx;

    // Word-aligned PCs, so the index starts at bit 2
    assign rd_idx = pc_i[IDX_BITS+1:2];
    assign wr_idx = wr_pc_i[IDX_BITS+1:2];

    // Full PC is kept as the tag
    assign hit_o    = valid_q[rd_idx] && (tag_mem[rd_idx] == pc_i);
    assign jump_o   = jump_mem[rd_idx];
    assign branch_o = branch_mem[rd_idx];
    assign target_o = target_mem[rd_idx];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_mem[wr_idx]    <= wr_pc_i;
            target_mem[wr_idx] <= wr_target_i;
            jump_mem[wr_idx]   <= wr_jump_i;
            branch_mem[wr_idx] <= wr_branch_i;
        end
    end

    // Trainer flags come from one resolved class, never both
    a_one_kind: assert property (
        @(posedge clk) disable iff (reset_i)
        we_i |-> !(wr_jump_i && wr_branch_i)
    ) else $error("btb written as both jump and branch");

endmodule

// ==== gshare_pht.sv ====
// Gshare pattern history table
module gshare_pht #(
    parameter int NUM_GHR_BITS = bp_pkg::DEFAULT_GHR_BITS
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [31:0]             pc_i,
    output logic [NUM_GHR_BITS-1:0] pht_index_o,
    output logic                    pht_taken_o,
    input  logic                    we_i,
    input  logic [NUM_GHR_BITS-1:0] wr_index_i,
    input  logic [1:0]              wr_count_i,
    output logic [1:0]              rd_count_o,
    input  logic                    ghr_shift_i,
    input  logic                    ghr_bit_i,
    input  logic                    ghr_clear_i
);

    localparam int PHT_ENTRIES = 1 << NUM_GHR_BITS;

    logic [1:0]              count_q [PHT_ENTRIES];
    logic [NUM_GHR_BITS-1:0] ghr_q;

    // Fetch index mixes PC bits with the global history
    assign pht_index_o = pc_i[NUM_GHR_BITS+1:2] ^ ghr_q;

    // MSB of the two-bit counter is the direction
    assign pht_taken_o = count_q[pht_index_o][1];

    // Old value for the trainer's saturating update
    assign rd_count_o = count_q[wr_index_i];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                count_q[i] <= 2'b00;
            end
        end else if (we_i) begin
            count_q[wr_index_i] <= wr_count_i;
        end
    end

    // Newest outcome enters at the top, older ones move right
    always_ff @(posedge clk) begin
        if (reset_i || ghr_clear_i) begin
            ghr_q <= '0;
        end else if (ghr_shift_i) begin
            ghr_q <= {ghr_bit_i, ghr_q[NUM_GHR_BITS-1:1]};
        end
    end

endmodule

// ==== pred_select.sv ====
// Fetch prediction decoder
module pred_select (
    input  logic [31:0] pc_i,
    input  logic        hit_i,
    input  logic        jump_i,
    input  logic        branch_i,
    input  logic [31:0] target_i,
    input  logic        pht_taken_i,
    output logic        pred_taken_o,
    output logic [31:0] pred_pc_o
);

    logic        jump_taken;
    logic        branch_taken;
    logic [31:0] seq_pc;

    assign seq_pc = pc_i + 32'd4;

    // Jumps in the buffer are always taken
    assign jump_taken = hit_i && jump_i;

    // Conditional branches follow the counter
    assign branch_taken = hit_i && branch_i && pht_taken_i;

    assign pred_taken_o = jump_taken || branch_taken;

    // Miss or not-taken branch falls through
    assign pred_pc_o = pred_taken_o ? target_i : seq_pc;

endmodule

// ==== branch_resolve.sv ====
// Execute-stage branch resolver
module branch_resolve #(
    parameter int NUM_GHR_BITS = bp_pkg::DEFAULT_GHR_BITS
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [31:0]             pc_i,
    input  logic                    pred_taken_i,
    input  logic [31:0]             pred_pc_i,
    input  logic                    hit_i,
    input  logic [NUM_GHR_BITS-1:0] pht_index_i,
    input  logic [6:0]              ex_op_i,
    input  logic                    ex_taken_i,
    input  logic [31:0]             ex_target_i,
    output logic                    mispredict_o,
    output logic [31:0]             redirect_pc_o,
    output logic                    res_valid_o,
    output bp_pkg::instr_class_e    res_class_o,
    output logic                    res_taken_o,
    output logic [31:0]             res_pc_o,
    output logic [31:0]             res_target_o,
    output logic                    res_hit_o,
    output logic [NUM_GHR_BITS-1:0] res_index_o,
    output logic                    res_wrong_o
);

    import bp_pkg::*;

    // Decode slot
    logic                    d_valid;
    logic [31:0]             d_pc;
    logic                    d_pred_taken;
    logic [31:0]             d_pred_pc;
    logic                    d_hit;
    logic [NUM_GHR_BITS-1:0] d_index;

    // Execute slot
    logic                    e_valid;
    logic [31:0]             e_pc;
    logic                    e_pred_taken;
    logic [31:0]             e_pred_pc;
    logic                    e_hit;
    logic [NUM_GHR_BITS-1:0] e_index;

    opcode_e      ex_op;
    instr_class_e ex_class;
    logic [31:0]  actual_pc;
    logic         dir_wrong;

    assign ex_op = opcode_e'(ex_op_i);

    always_comb begin
        case (ex_op)
            OP_BRANCH:       ex_class = CLASS_BRANCH;
            OP_JAL, OP_JALR: ex_class = CLASS_JUMP;
            default:         ex_class = CLASS_NONE;
        endcase
    end

    // Jumps are always taken, other instructions never
    assign res_taken_o = (ex_class == CLASS_JUMP) ||
                         ((ex_class == CLASS_BRANCH) && ex_taken_i);

    assign actual_pc = res_taken_o ? ex_target_i : (e_pc + 32'd4);
    assign dir_wrong = (ex_class == CLASS_BRANCH) && (res_taken_o != e_pred_taken);

    assign res_wrong_o   = (actual_pc != e_pred_pc) || dir_wrong;
    assign mispredict_o  = e_valid && res_wrong_o;
    assign redirect_pc_o = mispredict_o ? actual_pc : 32'd0;

    assign res_valid_o  = e_valid;
    assign res_class_o  = ex_class;
    assign res_pc_o     = e_pc;
    assign res_target_o = ex_target_i;
    assign res_hit_o    = e_hit;
    assign res_index_o  = e_index;

    // A mispredict kills both younger instructions
    always_ff @(posedge clk) begin
        if (reset_i) begin
            d_valid <= 1'b0;
            e_valid <= 1'b0;
        end else begin
            d_valid <= !mispredict_o;
            e_valid <= d_valid && !mispredict_o;
        end
    end

    always_ff @(posedge clk) begin
        d_pc         <= pc_i;
        d_pred_taken <= pred_taken_i;
        d_pred_pc    <= pred_pc_i;
        d_hit        <= hit_i;
        d_index      <= pht_index_i;
        e_pc         <= d_pc;
        e_pred_taken <= d_pred_taken;
        e_pred_pc    <= d_pred_pc;
        e_hit        <= d_hit;
        e_index      <= d_index;
    end

    // A valid execute slot needs a known outcome from the core
    a_outcome_known: assert property (
        @(posedge clk) disable iff (reset_i)
        e_valid |-> !$isunknown({ex_op_i, ex_taken_i, ex_target_i})
    ) else $error("unknown execute outcome for a valid slot");

endmodule

// ==== predictor_update.sv ====
// Predictor training logic
module predictor_update (
    input  logic                 res_valid_i,
    input  bp_pkg::instr_class_e res_class_i,
    input  logic                 res_taken_i,
    input  logic                 res_hit_i,
    input  logic                 res_wrong_i,
    input  logic [1:0]           rd_count_i,
    output logic                 btb_we_o,
    output logic                 btb_jump_o,
    output logic                 btb_branch_o,
    output logic                 pht_we_o,
    output logic [1:0]           pht_count_o,
    output logic                 ghr_shift_o,
    output logic                 ghr_bit_o
);

    import bp_pkg::*;

    logic is_branch;
    logic is_jump;

    assign is_branch = (res_class_i == CLASS_BRANCH);
    assign is_jump   = (res_class_i == CLASS_JUMP);

    // Allocate or repair a buffer entry only for taken control transfers
    assign btb_we_o = res_valid_i && (is_branch || is_jump) && res_taken_i &&
                      (!res_hit_i || res_wrong_i);

    assign btb_jump_o   = is_jump;
    assign btb_branch_o = is_branch;

    // Every resolved branch trains its counter
    assign pht_we_o = res_valid_i && is_branch;

    // Two-bit counter saturates at both ends
    always_comb begin
        if (res_taken_i) begin
            pht_count_o = (rd_count_i == 2'b11) ? 2'b11 : rd_count_i + 2'b01;
        end else begin
            pht_count_o = (rd_count_i == 2'b00) ? 2'b00 : rd_count_i - 2'b01;
        end
    end

    // History records resolved outcomes, not predictions
    assign ghr_shift_o = pht_we_o;
    assign ghr_bit_o   = res_taken_i;

endmodule

// ==== bp_top.sv ====
// Branch prediction top level
module bp_top #(
    parameter int NUM_BTB_ENTRIES = bp_pkg::DEFAULT_BTB_ENTRIES,
    parameter int NUM_GHR_BITS    = bp_pkg::DEFAULT_GHR_BITS
) (
    input  logic        clk,
    input  logic        reset_i,
    input  logic [31:0] pc_i,
    input  logic        ghr_clear_i,
    input  logic [6:0]  ex_op_i,
    input  logic        ex_taken_i,
    input  logic [31:0] ex_target_i,
    output logic        pred_taken_o,
    output logic [31:0] pred_pc_o,
    output logic        mispredict_o,
    output logic [31:0] redirect_pc_o
);

    logic                    btb_hit;
    logic                    btb_jump;
    logic                    btb_branch;
    logic [31:0]             btb_target;
    logic [NUM_GHR_BITS-1:0] pht_index;
    logic                    pht_taken;
    logic [1:0]              rd_count;

    logic                    res_valid;
    bp_pkg::instr_class_e    res_class;
    logic                    res_taken;
    logic [31:0]             res_pc;
    logic [31:0]             res_target;
    logic                    res_hit;
    logic [NUM_GHR_BITS-1:0] res_index;
    logic                    res_wrong;

    logic                    btb_we;
    logic                    btb_wr_jump;
    logic                    btb_wr_branch;
    logic                    pht_we;
    logic [1:0]              pht_count;
    logic                    ghr_shift;
    logic                    ghr_bit;

    btb #(
        .NUM_BTB_ENTRIES(NUM_BTB_ENTRIES)
    ) u_btb (
        .clk        (clk),
        .reset_i    (reset_i),
        .pc_i       (pc_i),
        .hit_o      (btb_hit),
        .jump_o     (btb_jump),
        .branch_o   (btb_branch),
        .target_o   (btb_target),
        .we_i       (btb_we),
        .wr_pc_i    (res_pc),
        .wr_target_i(res_target),
        .wr_jump_i  (btb_wr_jump),
        .wr_branch_i(btb_wr_branch)
    );

    gshare_pht #(
        .NUM_GHR_BITS(NUM_GHR_BITS)
    ) u_pht (
        .clk        (clk),
        .reset_i    (reset_i),
        .pc_i       (pc_i),
        .pht_index_o(pht_index),
        .pht_taken_o(pht_taken),
        .we_i       (pht_we),
        .wr_index_i (res_index),
        .wr_count_i (pht_count),
        .rd_count_o (rd_count),
        .ghr_shift_i(ghr_shift),
        .ghr_bit_i  (ghr_bit),
        .ghr_clear_i(ghr_clear_i)
    );

    pred_select u_pred (
        .pc_i        (pc_i),
        .hit_i       (btb_hit),
        .jump_i      (btb_jump),
        .branch_i    (btb_branch),
        .target_i    (btb_target),
        .pht_taken_i (pht_taken),
        .pred_taken_o(pred_taken_o),
        .pred_pc_o   (pred_pc_o)
    );

    branch_resolve #(
        .NUM_GHR_BITS(NUM_GHR_BITS)
    ) u_resolve (
        .clk          (clk),
        .reset_i      (reset_i),
        .pc_i         (pc_i),
        .pred_taken_i (pred_taken_o),
        .pred_pc_i    (pred_pc_o),
        .hit_i        (btb_hit),
        .pht_index_i  (pht_index),
        .ex_op_i      (ex_op_i),
        .ex_taken_i   (ex_taken_i),
        .ex_target_i  (ex_target_i),
        .mispredict_o (mispredict_o),
        .redirect_pc_o(redirect_pc_o),
        .res_valid_o  (res_valid),
        .res_class_o  (res_class),
        .res_taken_o  (res_taken),
        .res_pc_o     (res_pc),
        .res_target_o (res_target),
        .res_hit_o    (res_hit),
        .res_index_o  (res_index),
        .res_wrong_o  (res_wrong)
    );

    predictor_update u_update (
        .res_valid_i (res_valid),
        .res_class_i (res_class),
        .res_taken_i (res_taken),
        .res_hit_i   (res_hit),
        .res_wrong_i (res_wrong),
        .rd_count_i  (rd_count),
        .btb_we_o    (btb_we),
        .btb_jump_o  (btb_wr_jump),
        .btb_branch_o(btb_wr_branch),
        .pht_we_o    (pht_we),
        .pht_count_o (pht_count),
        .ghr_shift_o (ghr_shift),
        .ghr_bit_o   (ghr_bit)
    );

endmodule

// ==== tb_bp_top.sv ====
// Branch predictor testbench
module tb_bp_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 10;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 5;
    localparam int SLACK_CYCLES = 20;

    logic        clk;
    logic        reset_i;
    logic [31:0] pc_i;
    logic        ghr_clear_i;
    logic [6:0]  ex_op_i;
    logic        ex_taken_i;
    logic [31:0] ex_target_i;
    logic        pred_taken_o;
    logic [31:0] pred_pc_o;
    logic        mispredict_o;
    logic [31:0] redirect_pc_o;

    // Stimulus rows, one entry per cycle
    logic [31:0] row_pc[$];
    logic [31:0] row_op[$];
    logic [31:0] row_taken[$];
    logic [31:0] row_target[$];
    logic [31:0] row_clear[$];
    logic [31:0] exp_taken[$];
    logic [31:0] exp_pc[$];
    logic [31:0] exp_mispredict[$];
    logic [31:0] exp_redirect[$];

    int num_rows    = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    bp_top #(
        .NUM_BTB_ENTRIES(32),
        .NUM_GHR_BITS   (5)
    ) u_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .pc_i         (pc_i),
        .ghr_clear_i  (ghr_clear_i),
        .ex_op_i      (ex_op_i),
        .ex_taken_i   (ex_taken_i),
        .ex_target_i  (ex_target_i),
        .pred_taken_o (pred_taken_o),
        .pred_pc_o    (pred_pc_o),
        .mispredict_o (mispredict_o),
        .redirect_pc_o(redirect_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("error: %s expected %h actual %h",
                                      name, expected, actual));
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          count;
        int          line_no;
        string       line;
        logic [31:0] f [9];
        fd      = $fopen("bp_stimulus.txt", "r");
        line_no = 0;
        if (fd == 0) begin
            stop_on_failure("could not open the stimulus file bp_stimulus.txt");
        end
        while ($fgets(line, fd) != 0) begin
            line_no++;
            // Comment and blank lines carry no row
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                continue;
            end
            count = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
            if (count != 9) begin
                stop_on_failure($sformatf("stimulus line %0d does not hold nine fields",
                                          line_no));
            end
            row_pc.push_back(f[0]);
            row_op.push_back(f[1]);
            row_taken.push_back(f[2]);
            row_target.push_back(f[3]);
            row_clear.push_back(f[4]);
            exp_taken.push_back(f[5]);
            exp_pc.push_back(f[6]);
            exp_mispredict.push_back(f[7]);
            exp_redirect.push_back(f[8]);
        end
        $fclose(fd);
        num_rows = row_pc.size();
        if (num_rows == 0) begin
            stop_on_failure("the stimulus file holds no rows");
        end
    endtask

    task automatic apply_row(input int idx);
        pc_i        = row_pc[idx];
        ex_op_i     = row_op[idx][6:0];
        ex_taken_i  = row_taken[idx][0];
        ex_target_i = row_target[idx];
        ghr_clear_i = row_clear[idx][0];
    endtask

    task automatic check_row(input int idx);
        check_value($sformatf("row %0d pred_taken", idx), exp_taken[idx],
                    {31'd0, pred_taken_o});
        check_value($sformatf("row %0d pred_pc", idx), exp_pc[idx], pred_pc_o);
        check_value($sformatf("row %0d mispredict", idx), exp_mispredict[idx],
                    {31'd0, mispredict_o});
        check_value($sformatf("row %0d redirect_pc", idx), exp_redirect[idx], redirect_pc_o);
    endtask

    // Guards against a stalled run
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            stop_on_failure($sformatf("the run timed out after %0d cycles", cycle_count));
        end
    end

    initial begin
        reset_i     = 1'b1;
        pc_i        = 32'd0;
        ghr_clear_i = 1'b0;
        ex_op_i     = 7'h13;
        ex_taken_i  = 1'b0;
        ex_target_i = 32'd0;

        load_stimulus();
        cycle_limit = num_rows + RESET_CYCLES + SLACK_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset_i = 1'b0;

        for (int i = 0; i < num_rows; i++) begin
            apply_row(i);
            // Sample just ahead of the next rising edge
            #(CLK_PERIOD - DRIVE_DELAY - 1);
            check_row(i);
            @(posedge clk);
            #DRIVE_DELAY;
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== filelist.f ====
bp_pkg.sv
btb.sv
gshare_pht.sv
pred_select.sv
branch_resolve.sv
predictor_update.sv
bp_top.sv
tb_bp_top.sv

// ==== bp_stimulus.txt ====
# pc ex_op ex_taken ex_target ghr_clear exp_pred_taken exp_pred_pc exp_mispredict exp_redirect_pc
# All fields hex, one row per cycle; the ex_ fields are the outcome of the row two rows earlier
00001000 13 0 00000000 0 0 00001004 0 00000000
00001010 13 0 00000000 0 0 00001014 0 00000000
00001004 13 0 00000000 0 0 00001008 0 00000000
00001008 6f 1 00002000 0 0 0000100c 1 00002000
00002000 13 0 00000000 0 0 00002004 0 00000000
00001010 13 0 00000000 0 1 00002000 0 00000000
00001000 13 0 00000000 0 0 00001004 0 00000000
00001020 6f 1 00002000 0 0 00001024 0 00000000
00001000 13 0 00000000 0 0 00001004 0 00000000
00001004 63 1 00003000 1 0 00001008 1 00003000
00003000 13 0 00000000 0 0 00003004 0 00000000
00001020 13 0 00000000 0 0 00001024 0 00000000
00001000 13 0 00000000 0 0 00001004 0 00000000
00001004 63 1 00003000 1 0 00001008 1 00003000
00003000 13 0 00000000 0 0 00003004 0 00000000
00001020 13 0 00000000 0 1 00003000 0 00000000
00003000 13 0 00000000 0 0 00003004 0 00000000
00003004 63 1 00003000 0 0 00003008 0 00000000
00001020 13 0 00000000 1 0 00001024 0 00000000
00001020 13 0 00000000 0 1 00003000 0 00000000
00001000 63 0 00003000 0 0 00001004 0 00000000
00001020 63 0 00003000 0 1 00003000 1 00001024
00001024 6f 1 00005000 0 0 00001028 0 00000000
00001000 63 0 00003000 0 0 00001004 0 00000000
00001020 13 0 00000000 0 1 00003000 0 00000000
00003000 13 0 00000000 0 0 00003004 0 00000000
00003004 63 0 00003000 0 0 00003008 1 00001024
00001024 13 0 00000000 0 0 00001028 0 00000000
00001020 13 0 00000000 0 0 00001024 0 00000000
00001024 13 0 00000000 0 0 00001028 0 00000000
00001028 63 0 00003000 0 0 0000102c 0 00000000
